// File: include/fp_mul_defines.svh
// format constants, APB register offsets and bus widths
// for the single precision multiply unit
`ifndef FP_MUL_DEFINES_SVH
`define FP_MUL_DEFINES_SVH

// ====================================================================
// single precision number format
// ====================================================================
`define FP_EXP_BIAS 127
`define FP_EXP_MAX  255

// returned for infinity times zero
// sign set, exponent all ones, top mantissa bit set
`define FP_DEFAULT_NAN 32'hFFC0_0000

// ====================================================================
// APB bus and register map
// ====================================================================
`define APB_ADDR_W 8
`define APB_DATA_W 32

`define REG_OP_A   8'h00
`define REG_OP_B   8'h04
`define REG_CTRL   8'h08
`define REG_RESULT 8'h0C
`define REG_STATUS 8'h10

// status register bit positions
`define STATUS_DONE_BIT      0
`define STATUS_BUSY_BIT      1
`define STATUS_INVALID_BIT   2
`define STATUS_OVERFLOW_BIT  3
`define STATUS_UNDERFLOW_BIT 4

`endif

// File: verilog/fp_pkg.sv
// number format types for the single precision multiply core
package fp_pkg;

  // packed word, sign 31, exponent 30:23, mantissa 22:0
  typedef logic [31:0] fp32_t;

  // biased exponent field
  typedef logic [7:0] fp_exp_t;

  // stored mantissa, hidden bit not included
  typedef logic [22:0] fp_man_t;

  // significand with the hidden bit in front
  typedef logic [23:0] fp_sig_t;

  // full product of two significands
  // bit 47 set means the product is in [2,4)
  typedef logic [47:0] fp_prod_t;

  // signed exponent sum after bias removal
  // range -127 to 383, so two extra bits are enough
  // to see both overflow and underflow
  typedef logic signed [9:0] fp_exp_sum_t;

endpackage

// File: verilog/fp_mul_regs_pkg.sv
// APB bus types and the control state encoding
// for the multiply unit register block
`include "fp_mul_defines.svh"

package fp_mul_regs_pkg;

  // bus address and data words
  typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`APB_DATA_W-1:0] apb_data_t;

  // control FSM
  // idle after reset, busy while an operation is in flight,
  // done once the result has been captured
  typedef enum logic [1:0] {
    mul_idle = 2'd0,
    mul_busy = 2'd1,
    mul_done = 2'd2
  } mul_state_e;

endpackage

// File: verilog/fp_special_case.sv
// operand classification for the multiply core
// produces the override result and the invalid flag
`timescale 1ns/10ps
`include "fp_mul_defines.svh"

module fp_special_case (
  input  fp_pkg::fp32_t op_a,
  input  fp_pkg::fp32_t op_b,
  output logic          use_special,
  output fp_pkg::fp32_t special_result,
  output logic          invalid
);
  import fp_pkg::*;

  logic    sign_out;
  fp_exp_t exp_a;
  fp_exp_t exp_b;
  fp_man_t man_a;
  fp_man_t man_b;
  logic    a_nan;
  logic    b_nan;
  logic    a_inf;
  logic    b_inf;
  logic    a_zero;
  logic    b_zero;

  assign sign_out = op_a[31] ^ op_b[31];
  assign exp_a    = op_a[30:23];
  assign exp_b    = op_b[30:23];
  assign man_a    = op_a[22:0];
  assign man_b    = op_b[22:0];

  // each operand checks its own mantissa for NaN
  assign a_nan = (exp_a == fp_exp_t'(`FP_EXP_MAX)) && (man_a != '0);
  assign b_nan = (exp_b == fp_exp_t'(`FP_EXP_MAX)) && (man_b != '0);
  assign a_inf = (exp_a == fp_exp_t'(`FP_EXP_MAX)) && (man_a == '0);
  assign b_inf = (exp_b == fp_exp_t'(`FP_EXP_MAX)) && (man_b == '0);

  // subnormals are flushed, so a zero exponent means zero
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);

  // infinity times zero, a NaN operand cannot be infinity
  assign invalid = (a_inf && b_zero) || (b_inf && a_zero);

  // priority chain, first match wins
  always_comb begin
    use_special    = 1'b1;
    special_result = '0;
    if (a_nan) begin
      special_result = op_a;
    end else if (b_nan) begin
      special_result = op_b;
    end else if (invalid) begin
      special_result = `FP_DEFAULT_NAN;
    end else if (a_inf || b_inf) begin
      special_result = {sign_out, fp_exp_t'(`FP_EXP_MAX), fp_man_t'(0)};
    end else if (a_zero || b_zero) begin
      // other operand is finite here
      special_result = {sign_out, fp_exp_t'(0), fp_man_t'(0)};
    end else begin
      use_special = 1'b0;
    end
  end

endmodule

// File: verilog/fp_multiplier.sv
// two stage single precision multiply core
// stage 1 forms sign, exponent sum and significand product
// stage 2 normalizes, handles range and applies the override
`timescale 1ns/10ps
`include "fp_mul_defines.svh"

module fp_multiplier (
  input  logic          clk,
  input  logic          reset,
  input  logic          mul_valid,
  input  fp_pkg::fp32_t op_a,
  input  fp_pkg::fp32_t op_b,
  output logic          res_valid,
  output fp_pkg::fp32_t result,
  output logic          invalid,
  output logic          overflow,
  output logic          underflow
);
  import fp_pkg::*;

  // ====================================================================
  // stage 1
  // ====================================================================
  fp_sig_t     sig_a;
  fp_sig_t     sig_b;
  fp_prod_t    prod;
  fp_exp_sum_t exp_sum;
  logic        sc_use_special;
  fp32_t       sc_special_result;
  logic        sc_invalid;

  logic        s1_valid;
  logic        s1_sign;
  fp_exp_sum_t s1_exp;
  fp_prod_t    s1_prod;
  logic        s1_use_special;
  fp32_t       s1_special_result;
  logic        s1_invalid;

  // hidden bit in front of each stored mantissa
  assign sig_a = {1'b1, op_a[22:0]};
  assign sig_b = {1'b1, op_b[22:0]};
  assign prod  = fp_prod_t'(sig_a) * fp_prod_t'(sig_b);

  // both exponents zero extended before the signed sum
  assign exp_sum = fp_exp_sum_t'({2'b00, op_a[30:23]})
                 + fp_exp_sum_t'({2'b00, op_b[30:23]})
                 - fp_exp_sum_t'(`FP_EXP_BIAS);

  fp_special_case u_special_case (
    .op_a           (op_a),
    .op_b           (op_b),
    .use_special    (sc_use_special),
    .special_result (sc_special_result),
    .invalid        (sc_invalid)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= mul_valid;
    end
  end

  // payload loads only with a new operation
  always_ff @(posedge clk) begin
    if (mul_valid) begin
      s1_sign           <= op_a[31] ^ op_b[31];
      s1_exp            <= exp_sum;
      s1_prod           <= prod;
      s1_use_special    <= sc_use_special;
      s1_special_result <= sc_special_result;
      s1_invalid        <= sc_invalid;
    end
  end

  // ====================================================================
  // stage 2
  // ====================================================================
  logic        carry;
  fp_exp_sum_t exp_final;
  fp_man_t     man_norm;
  logic        exp_over;
  logic        exp_under;
  fp32_t       result_d;
  logic        invalid_d;
  logic        overflow_d;
  logic        underflow_d;

  // product in [2,4) shifts right by one and bumps the exponent
  assign carry     = s1_prod[47];
  assign exp_final = s1_exp + fp_exp_sum_t'({9'd0, carry});
  assign man_norm  = carry ? s1_prod[46:24] : s1_prod[45:23];

  // signed compares on the widened exponent
  assign exp_over  = (exp_final >= fp_exp_sum_t'(`FP_EXP_MAX));
  assign exp_under = (exp_final <= fp_exp_sum_t'(0));

  // truncation toward zero, extra product bits are dropped
  always_comb begin
    result_d    = {s1_sign, exp_final[7:0], man_norm};
    invalid_d   = 1'b0;
    overflow_d  = 1'b0;
    underflow_d = 1'b0;
    if (s1_use_special) begin
      result_d  = s1_special_result;
      invalid_d = s1_invalid;
    end else if (exp_over) begin
      result_d   = {s1_sign, fp_exp_t'(`FP_EXP_MAX), fp_man_t'(0)};
      overflow_d = 1'b1;
    end else if (exp_under) begin
      result_d    = {s1_sign, fp_exp_t'(0), fp_man_t'(0)};
      underflow_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result    <= result_d;
      invalid   <= invalid_d;
      overflow  <= overflow_d;
      underflow <= underflow_d;
    end
  end

  // fixed two cycle latency through both stages
  a_res_valid_latency : assert property (
    @(posedge clk) disable iff (reset) res_valid == $past(mul_valid, 2)
  ) else $error("res_valid does not follow mul_valid by two cycles");

endmodule

// File: verilog/fp_mul_apb_regs.sv
// APB slave for the multiply unit
// register map, start control, result capture and error response
`timescale 1ns/10ps
`include "fp_mul_defines.svh"

module fp_mul_apb_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  fp_mul_regs_pkg::apb_addr_t paddr,
  input  fp_mul_regs_pkg::apb_data_t pwdata,
  output fp_mul_regs_pkg::apb_data_t prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       mul_valid,
  output fp_pkg::fp32_t              op_a,
  output fp_pkg::fp32_t              op_b,
  input  logic                       res_valid,
  input  fp_pkg::fp32_t              result,
  input  logic                       invalid,
  input  logic                       overflow,
  input  logic                       underflow
);
  import fp_pkg::*;
  import fp_mul_regs_pkg::*;

  mul_state_e state;
  fp32_t      op_a_q;
  fp32_t      op_b_q;
  fp32_t      result_q;
  logic       invalid_q;
  logic       overflow_q;
  logic       underflow_q;
  apb_data_t  status_word;

  logic       wr_access;
  logic       rd_access;
  logic       addr_hit;
  logic       ro_hit;
  logic       start_req;
  logic       start_busy;

  // ====================================================================
  // access decode
  // ====================================================================
  assign wr_access = psel && penable && pwrite;
  assign rd_access = psel && penable && !pwrite;

  assign addr_hit = (paddr == `REG_OP_A) || (paddr == `REG_OP_B) ||
                    (paddr == `REG_CTRL) || (paddr == `REG_RESULT) ||
                    (paddr == `REG_STATUS);
  assign ro_hit   = (paddr == `REG_RESULT) || (paddr == `REG_STATUS);

  // start is bit 0 of CTRL, rejected while busy
  assign start_req  = wr_access && (paddr == `REG_CTRL) && pwdata[0];
  assign start_busy = start_req && (state == mul_busy);
  assign mul_valid  = start_req && (state != mul_busy);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = (psel && penable && !addr_hit) || (wr_access && ro_hit) || start_busy;

  // operands go straight to the core, sampled there on mul_valid
  assign op_a = op_a_q;
  assign op_b = op_b_q;

  // ====================================================================
  // control FSM and registers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mul_idle;
    end else begin
      case (state)
        mul_idle, mul_done: if (mul_valid) state <= mul_busy;
        mul_busy:           if (res_valid) state <= mul_done;
        default:            state <= mul_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      op_a_q      <= '0;
      op_b_q      <= '0;
      result_q    <= '0;
      invalid_q   <= 1'b0;
      overflow_q  <= 1'b0;
      underflow_q <= 1'b0;
    end else begin
      // operand writes allowed in any state
      if (wr_access && (paddr == `REG_OP_A)) op_a_q <= pwdata;
      if (wr_access && (paddr == `REG_OP_B)) op_b_q <= pwdata;
      // sticky flags, cleared by a new start
      if (mul_valid) begin
        invalid_q   <= 1'b0;
        overflow_q  <= 1'b0;
        underflow_q <= 1'b0;
      end else if (res_valid) begin
        result_q    <= result;
        invalid_q   <= invalid_q | invalid;
        overflow_q  <= overflow_q | overflow;
        underflow_q <= underflow_q | underflow;
      end
    end
  end

  // ====================================================================
  // read path
  // ====================================================================
  always_comb begin
    status_word = '0;
    status_word[`STATUS_DONE_BIT]      = (state == mul_done);
    status_word[`STATUS_BUSY_BIT]      = (state == mul_busy);
    status_word[`STATUS_INVALID_BIT]   = invalid_q;
    status_word[`STATUS_OVERFLOW_BIT]  = overflow_q;
    status_word[`STATUS_UNDERFLOW_BIT] = underflow_q;
  end

  // CTRL reads back as zero
  always_comb begin
    prdata = '0;
    if (rd_access) begin
      case (paddr)
        `REG_OP_A:   prdata = op_a_q;
        `REG_OP_B:   prdata = op_b_q;
        `REG_RESULT: prdata = result_q;
        `REG_STATUS: prdata = status_word;
        default:     prdata = '0;
      endcase
    end
  end

  // access phase only follows a selected setup phase
  a_penable_psel : assert property (
    @(posedge clk) disable iff (reset) penable |-> psel
  ) else $error("penable without psel");

  // the core only answers an operation this block issued
  a_res_valid_not_idle : assert property (
    @(posedge clk) disable iff (reset) res_valid |-> (state != mul_idle)
  ) else $error("res_valid arrived in idle");

endmodule

// File: verilog/fp_mul_top.sv
// top level of the APB floating-point multiply unit
// register block feeding the two stage multiply core
`timescale 1ns/10ps

module fp_mul_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  fp_mul_regs_pkg::apb_addr_t paddr,
  input  fp_mul_regs_pkg::apb_data_t pwdata,
  output fp_mul_regs_pkg::apb_data_t prdata,
  output logic                       pready,
  output logic                       pslverr
);
  import fp_pkg::*;

  // issue side
  logic  mul_valid;
  fp32_t op_a;
  fp32_t op_b;

  // result side
  logic  res_valid;
  fp32_t result;
  logic  invalid;
  logic  overflow;
  logic  underflow;

  fp_mul_apb_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .mul_valid (mul_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .res_valid (res_valid),
    .result    (result),
    .invalid   (invalid),
    .overflow  (overflow),
    .underflow (underflow)
  );

  fp_multiplier u_multiplier (
    .clk       (clk),
    .reset     (reset),
    .mul_valid (mul_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .res_valid (res_valid),
    .result    (result),
    .invalid   (invalid),
    .overflow  (overflow),
    .underflow (underflow)
  );

endmodule

// File: sim/tb_fp_mul_top.sv
// directed testbench for the APB floating-point multiply unit
// reference model, APB access tasks and the test sequence
`timescale 1ns/10ps
`include "fp_mul_defines.svh"

module tb_fp_mul_top;

  logic                   clk;
  logic                   reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`APB_DATA_W-1:0] pwdata;
  logic [`APB_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;

  integer      seed;
  integer      error_count;
  integer      check_count;
  logic [31:0] last_result;
  logic [31:0] rd_dummy;
  logic [31:0] op_x;
  logic [31:0] op_y;
  integer      i;

  fp_mul_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ====================================================================
  // reference model
  // ====================================================================
  // returns {invalid, overflow, underflow, result}
  function automatic logic [34:0] model_mul(input logic [31:0] a, input logic [31:0] b);
    logic        sr;
    integer      ea;
    integer      eb;
    integer      e;
    logic [47:0] p;
    logic [22:0] m;
    logic [31:0] r;
    logic        inv;
    logic        ovf;
    logic        unf;
    sr  = a[31] ^ b[31];
    ea  = a[30:23];
    eb  = b[30:23];
    inv = 1'b0;
    ovf = 1'b0;
    unf = 1'b0;
    if (ea == 255 && a[22:0] != 0) begin
      r = a;
    end else if (eb == 255 && b[22:0] != 0) begin
      r = b;
    end else if ((ea == 255 && eb == 0) || (eb == 255 && ea == 0)) begin
      r   = `FP_DEFAULT_NAN;
      inv = 1'b1;
    end else if (ea == 255 || eb == 255) begin
      r = {sr, 8'hFF, 23'd0};
    end else if (ea == 0 || eb == 0) begin
      // subnormals count as zero
      r = {sr, 31'd0};
    end else begin
      e = ea + eb - `FP_EXP_BIAS;
      p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
      if (p[47]) begin
        m = p[46:24];
        e = e + 1;
      end else begin
        m = p[45:23];
      end
      if (e >= 255) begin
        r   = {sr, 8'hFF, 23'd0};
        ovf = 1'b1;
      end else if (e <= 0) begin
        r   = {sr, 31'd0};
        unf = 1'b1;
      end else begin
        r = {sr, e[7:0], m};
      end
    end
    model_mul = {inv, ovf, unf, r};
  endfunction

  // ====================================================================
  // APB access tasks
  // ====================================================================
  // called 1 ns after a rising edge, returns 1 ns after the completing edge
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic exp_err,
                            output logic [31:0] rdata);
    integer wait_cycles;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // sample mid cycle, well away from both edges
    #8;
    wait_cycles = 0;
    while (pready !== 1'b1 && wait_cycles < 16) begin
      @(posedge clk);
      #9;
      wait_cycles = wait_cycles + 1;
    end
    if (pready !== 1'b1) begin
      error_count = error_count + 1;
      $display("APB access to 0x%02h never saw pready", addr);
    end
    rdata       = prdata;
    check_count = check_count + 1;
    if (pslverr !== exp_err) begin
      error_count = error_count + 1;
      $display("ERROR %0t: pslverr %b at addr 0x%02h, expected %b",
               $time, pslverr, addr, exp_err);
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                          output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, exp_err, data);
  endtask

  // read one register and compare
  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_val);
    logic [31:0] got;
    apb_read(addr, 1'b0, got);
    check_count = check_count + 1;
    if (got !== exp_val) begin
      error_count = error_count + 1;
      $display("ERROR %0t: reg 0x%02h read %h, expected %h", $time, addr, got, exp_val);
    end
  endtask

  // ====================================================================
  // multiply sequence
  // ====================================================================
  task automatic start_mul(input logic [31:0] a, input logic [31:0] b);
    apb_write(`REG_OP_A, a, 1'b0);
    apb_write(`REG_OP_B, b, 1'b0);
    apb_write(`REG_CTRL, 32'd1, 1'b0);
  endtask

  // poll done, then compare RESULT and STATUS with the model
  task automatic finish_mul(input logic [31:0] a, input logic [31:0] b);
    logic [34:0] expected;
    logic [31:0] status;
    logic [31:0] exp_status;
    logic [31:0] res;
    integer      polls;
    expected = model_mul(a, b);
    status   = 32'd0;
    polls    = 0;
    while (!status[`STATUS_DONE_BIT] && polls < 20) begin
      apb_read(`REG_STATUS, 1'b0, status);
      polls = polls + 1;
    end
    if (!status[`STATUS_DONE_BIT]) begin
      error_count = error_count + 1;
      $display("done bit never set after %0d STATUS polls for %h * %h", polls, a, b);
    end
    apb_read(`REG_RESULT, 1'b0, res);
    last_result = res;
    exp_status  = 32'd0;
    exp_status[`STATUS_DONE_BIT]      = 1'b1;
    exp_status[`STATUS_INVALID_BIT]   = expected[34];
    exp_status[`STATUS_OVERFLOW_BIT]  = expected[33];
    exp_status[`STATUS_UNDERFLOW_BIT] = expected[32];
    check_count = check_count + 2;
    if (res !== expected[31:0]) begin
      error_count = error_count + 1;
      $display("ERROR %0t: %h * %h gave %h, expected %h", $time, a, b, res, expected[31:0]);
    end
    if (status !== exp_status) begin
      error_count = error_count + 1;
      $display("ERROR %0t: %h * %h status %h, expected %h", $time, a, b, status, exp_status);
    end
  endtask

  task automatic run_mul(input logic [31:0] a, input logic [31:0] b);
    start_mul(a, b);
    finish_mul(a, b);
  endtask

  // hand computed value on top of the model
  task automatic expect_value(input logic [31:0] exp_val);
    check_count = check_count + 1;
    if (last_result !== exp_val) begin
      error_count = error_count + 1;
      $display("ERROR %0t: result %h, expected %h", $time, last_result, exp_val);
    end
  endtask

  // normal operand with exponent kept clear of both range limits
  task automatic random_normal(output logic [31:0] value);
    logic [31:0] r_sign;
    logic [31:0] r_man;
    integer      r_exp;
    r_sign = $random(seed);
    r_man  = $random(seed);
    r_exp  = 64 + ({$random(seed)} % 126);
    value  = {r_sign[0], r_exp[7:0], r_man[22:0]};
  endtask

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    seed        = 32'h91166399;
    error_count = 0;
    check_count = 0;
    last_result = 32'd0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // registers after reset, STATUS idle
    read_expect(`REG_OP_A, 32'd0);
    read_expect(`REG_OP_B, 32'd0);
    read_expect(`REG_CTRL, 32'd0);
    read_expect(`REG_RESULT, 32'd0);
    read_expect(`REG_STATUS, 32'd0);

    // fixed normal products
    run_mul(32'h4000_0000, 32'h4040_0000);
    expect_value(32'h40C0_0000);
    run_mul(32'hBFC0_0000, 32'h4080_0000);
    expect_value(32'hC0C0_0000);
    run_mul(32'h3F80_0000, 32'h3F80_0000);
    expect_value(32'h3F80_0000);

    // random normal pairs
    for (i = 0; i < 50; i = i + 1) begin
      random_normal(op_x);
      random_normal(op_y);
      run_mul(op_x, op_y);
    end

    // NaN in either operand, infinities and zeros
    run_mul(32'h7FC0_0001, 32'h4000_0000);
    expect_value(32'h7FC0_0001);
    run_mul(32'h4040_0000, 32'hFF80_0123);
    expect_value(32'hFF80_0123);
    run_mul(32'h7F80_0000, 32'hC000_0000);
    expect_value(32'hFF80_0000);
    run_mul(32'h7F80_0000, 32'h0000_0000);
    expect_value(`FP_DEFAULT_NAN);
    run_mul(32'h8000_0000, 32'h40A0_0000);

    // range limits, the last one overflows only through the carry
    run_mul(32'h7F00_0000, 32'h7F00_0000);
    run_mul(32'hFF00_0000, 32'h7F00_0000);
    run_mul(32'h7F40_0000, 32'h3FC0_0000);
    run_mul(32'h0080_0000, 32'h0080_0000);
    run_mul(32'h8080_0000, 32'h0080_0000);
    run_mul(32'h0000_0001, 32'h4000_0000);

    // bus errors
    apb_read(8'h14, 1'b1, rd_dummy);
    apb_write(`REG_RESULT, 32'h1234_5678, 1'b1);
    apb_write(`REG_STATUS, 32'h0000_001F, 1'b1);

    // second start lands while the first is in flight
    start_mul(32'h4000_0000, 32'h4040_0000);
    apb_write(`REG_CTRL, 32'd1, 1'b1);
    finish_mul(32'h4000_0000, 32'h4040_0000);

    // back to back, each returns its own product
    run_mul(32'h4080_0000, 32'hC040_0000);
    run_mul(32'h3FC0_0000, 32'h3FC0_0000);

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
verilog/fp_pkg.sv
verilog/fp_mul_regs_pkg.sv
verilog/fp_special_case.sv
verilog/fp_multiplier.sv
verilog/fp_mul_apb_regs.sv
verilog/fp_mul_top.sv
sim/tb_fp_mul_top.sv

// File: Bender.yml
package:
  name: fp_mul_apb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fp_pkg.sv
      - verilog/fp_mul_regs_pkg.sv
      - verilog/fp_special_case.sv
      - verilog/fp_multiplier.sv
      - verilog/fp_mul_apb_regs.sv
      - verilog/fp_mul_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_fp_mul_top.sv
